// File: aer_defines.svh
`ifndef AER_DEFINES_SVH
`define AER_DEFINES_SVH

// --------------------------------------------------------------------
// Pixel block geometry
// --------------------------------------------------------------------

`define AER_ROWS    4           // Rows in one pixel block
`define AER_COLS    4           // Columns in one pixel block

// Row and column addresses share one width
`define AER_ADDR_W  2           // Bits to address a row or a column

`endif

// File: aer_event_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module aer_event_encoder
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire aer_pkg::pix_grant_t  grant_i,          // Pixel grant from arbitration
    input  wire logic                 grant_valid_i,
    output aer_pkg::aer_event_t       event_o,          // Addressed event word
    output logic                      event_valid_o     // One-cycle event strobe
);

    aer_pkg::pix_map_t expect_map;                      // Map implied by addresses
    logic              map_ok;

    // --------------------------------------------------------------------
    // Consistency between one-hot map and addresses
    // --------------------------------------------------------------------

    always_comb
    begin
        expect_map                           = '0;
        expect_map[grant_i.row][grant_i.col] = 1'b1;
        map_ok                               = (grant_i.map == expect_map);
    end

    // --------------------------------------------------------------------
    // Event register
    // --------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            event_o       <= '0;
            event_valid_o <= 1'b0;
        end
        else
        begin
            event_valid_o <= grant_valid_i && map_ok;   // Bad map gives no strobe
            if (grant_valid_i)
            begin
                event_o.row <= grant_i.row;
                event_o.col <= grant_i.col;
            end
        end
    end

endmodule

`default_nettype wire

// File: aer_pkg.sv
`default_nettype none

`include "aer_defines.svh"

package aer_pkg;

    // --------------------------------------------------------------------
    // Arbitration state and pixel maps
    // --------------------------------------------------------------------

    typedef enum logic [1:0]
    {
        IDLE      = 2'b00,                              // No arbitration running
        ROW_GRANT = 2'b01,                              // Row picked, columns not yet
        COL_GRANT = 2'b10                               // Serving columns of one row
    } arb_state_e;

    typedef logic [`AER_ROWS-1:0][`AER_COLS-1:0] pix_map_t;  // [row][col] bit map

    typedef struct packed
    {
        pix_map_t               map;                    // One-hot pixel grant
        logic [`AER_ADDR_W-1:0] row;                    // Granted row address
        logic [`AER_ADDR_W-1:0] col;                    // Granted column address
    } pix_grant_t;

    typedef struct packed
    {
        logic [`AER_ADDR_W-1:0] row;                    // Event row address
        logic [`AER_ADDR_W-1:0] col;                    // Event column address
    } aer_event_t;

    // --------------------------------------------------------------------
    // Round-robin search shared by both arbiters
    // --------------------------------------------------------------------

    // First set request at or after start, wrapping once around the block
    function automatic logic [`AER_ADDR_W-1:0] rr_pick(
        input logic [`AER_ROWS-1:0]   req,              // Same width for rows and columns
        input logic [`AER_ADDR_W-1:0] start
    );
        logic [`AER_ADDR_W-1:0] idx;
        logic [`AER_ADDR_W-1:0] pick;
        logic                   found;
        pick  = start;                                  // Don't care when req is empty
        found = 1'b0;
        for (int k = 0; k < `AER_ROWS; k++)
        begin
            idx = start + `AER_ADDR_W'(k);              // Wraps in address width
            if (!found && req[idx])
            begin
                pick  = idx;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

endpackage

`default_nettype wire

// File: aer_readout_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module aer_readout_asserts
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire aer_pkg::pix_grant_t grant_i,           // Grant from pixel_level_0
    input  wire logic                grant_valid_i,
    input  wire logic                event_valid_i      // Encoder event strobe
);

    int fail_cnt = 0;                                   // Failed assertion count

    // --------------------------------------------------------------------
    // Grant and event strobe properties
    // --------------------------------------------------------------------

    grant_onehot_a: assert property (@(posedge clk) disable iff (rst_n)
        grant_valid_i |-> $onehot(grant_i.map))
    else
    begin
        $error("grant map is not one-hot");
        fail_cnt++;
    end

    event_follows_a: assert property (@(posedge clk) disable iff (rst_n)
        grant_valid_i |=> event_valid_i)
    else
    begin
        $error("grant gave no event one cycle later");
        fail_cnt++;
    end

    event_has_grant_a: assert property (@(posedge clk) disable iff (rst_n)
        event_valid_i |-> $past(grant_valid_i))
    else
    begin
        $error("event strobe without a grant in the cycle before");
        fail_cnt++;
    end

    // Strobes stay low while reset is asserted
    reset_quiet_a: assert property (@(posedge clk)
        rst_n |-> (!grant_valid_i && !event_valid_i))
    else
    begin
        $error("strobe high during reset");
        fail_cnt++;
    end

endmodule

bind aer_event_encoder aer_readout_asserts i_aer_readout_asserts
(
    .clk           (clk),
    .rst_n         (rst_n),
    .grant_i       (grant_i),
    .grant_valid_i (grant_valid_i),
    .event_valid_i (event_valid_o)
);

`default_nettype wire

// File: aer_readout_top.sv
`timescale 1ns/1ns
`default_nettype none

module aer_readout_top
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                enable_i,          // Allows arbitration
    input  wire aer_pkg::pix_map_t   hit_i,             // Pixel hit strobes
    input  wire logic                hit_valid_i,
    output aer_pkg::aer_event_t      event_o,           // Row and column of the event
    output logic                     event_valid_o,
    output logic                     req_o,             // Block has pending hits
    output logic                     grp_release_o      // Row sweep completed
);

    aer_pkg::pix_map_t   pending;                       // Stage 1 to stage 2
    aer_pkg::pix_grant_t grant;                         // Stage 2 to stages 1 and 3
    logic                grant_valid;

    pixel_event_latch i_pixel_event_latch
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .hit_i         (hit_i),
        .hit_valid_i   (hit_valid_i),
        .grant_i       (grant),
        .grant_valid_i (grant_valid),
        .pending_o     (pending)
    );

    pixel_level_0 i_pixel_level_0
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable_i      (enable_i),
        .pending_i     (pending),
        .grant_o       (grant),
        .grant_valid_o (grant_valid),
        .req_o         (req_o),
        .grp_release_o (grp_release_o)
    );

    aer_event_encoder i_aer_event_encoder
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .grant_i       (grant),
        .grant_valid_i (grant_valid),
        .event_o       (event_o),
        .event_valid_o (event_valid_o)
    );

endmodule

`default_nettype wire

// File: col_rr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "aer_defines.svh"

module col_rr_arbiter
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   enable_i,       // Arbitrate this cycle
    input  wire logic [`AER_COLS-1:0]   req_i,          // Active columns of selected row
    output logic      [`AER_COLS-1:0]   gnt_o,          // One-hot column grant, one cycle
    output logic      [`AER_ADDR_W-1:0] col_addr_o      // Index of granted column
);

    logic [`AER_ADDR_W-1:0] ptr_q;                      // Last granted column
    logic [`AER_ADDR_W-1:0] pick;
    logic                   any_req;

    assign any_req = |req_i;
    assign pick    = aer_pkg::rr_pick(req_i, ptr_q + 1'b1);  // Strictly after pointer

    // --------------------------------------------------------------------
    // Grant lasts one cycle, zero grant marks an exhausted row
    // --------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            gnt_o      <= '0;
            col_addr_o <= '0;
            ptr_q      <= '0;                           // Pointer at column 0
        end
        else
        begin
            gnt_o <= '0;                                // Dropped unless re-granted
            if (enable_i && any_req)
            begin
                gnt_o      <= `AER_COLS'(1) << pick;
                col_addr_o <= pick;
                ptr_q      <= pick;                     // Next search starts after it
            end
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
aer_pkg.sv
pixel_event_latch.sv
row_rr_arbiter.sv
col_rr_arbiter.sv
pixel_level_0.sv
aer_event_encoder.sv
aer_readout_top.sv
aer_readout_asserts.sv
tb_aer_readout.sv

// File: pixel_event_latch.sv
`timescale 1ns/1ns
`default_nettype none

`include "aer_defines.svh"

module pixel_event_latch
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire aer_pkg::pix_map_t  hit_i,              // Pixel hit strobes
    input  wire logic               hit_valid_i,        // Qualifies hit_i
    input  wire aer_pkg::pix_grant_t grant_i,           // Grant from arbitration
    input  wire logic               grant_valid_i,      // Qualifies grant_i
    output aer_pkg::pix_map_t       pending_o           // Hits waiting for a grant
);

    aer_pkg::pix_map_t pending_q;                       // Latched hits
    aer_pkg::pix_map_t pending_d;
    aer_pkg::pix_map_t set_map;                         // Bits to set this cycle
    aer_pkg::pix_map_t clr_map;                         // Bit to clear this cycle

    // --------------------------------------------------------------------
    // Set by hits, cleared by grants
    // --------------------------------------------------------------------

    always_comb
    begin
        set_map = '0;
        clr_map = '0;
        if (hit_valid_i)
        begin
            set_map = hit_i;                            // Every strobed pixel
        end
        if (grant_valid_i)
        begin
            clr_map = grant_i.map;                      // One-hot granted pixel
        end
        // Set wins over clear so a fresh hit on the granted pixel survives
        pending_d = (pending_q & ~clr_map) | set_map;
    end

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            pending_q <= '0;                            // Nothing pending
        end
        else
        begin
            pending_q <= pending_d;
        end
    end

    assign pending_o = pending_q;

endmodule

`default_nettype wire

// File: pixel_level_0.sv
`timescale 1ns/1ns
`default_nettype none

`include "aer_defines.svh"

module pixel_level_0
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                enable_i,          // Arbitration allowed
    input  wire aer_pkg::pix_map_t   pending_i,         // Latched pixel hits
    output aer_pkg::pix_grant_t      grant_o,           // Pixel grant with addresses
    output logic                     grant_valid_o,     // One grant per cycle at most
    output logic                     req_o,             // Any pixel pending
    output logic                     grp_release_o      // Row sweep wrapped
);

    aer_pkg::arb_state_e    state_q;
    aer_pkg::arb_state_e    state_d;
    logic                   row_en;                     // Row arbiter enable
    logic                   col_en;                     // Column arbiter enable
    logic [`AER_ROWS-1:0]   row_req;                    // Rows with pending hits
    logic [`AER_ROWS-1:0]   row_gnt;
    logic [`AER_ADDR_W-1:0] row_addr;
    logic [`AER_COLS-1:0]   col_req;                    // Columns of the granted row
    logic [`AER_COLS-1:0]   col_gnt;
    logic [`AER_ADDR_W-1:0] col_addr;

    // --------------------------------------------------------------------
    // Request reduction
    // --------------------------------------------------------------------

    always_comb
    begin
        for (int i = 0; i < `AER_ROWS; i++)
        begin
            row_req[i] = |pending_i[i];                 // OR across the row
        end
        // Column in flight is still pending until the next edge
        col_req = pending_i[row_addr] & ~col_gnt;
    end

    assign req_o = |pending_i;

    // --------------------------------------------------------------------
    // Arbitration FSM
    // --------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            state_q <= aer_pkg::IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d = state_q;
        row_en  = 1'b0;
        col_en  = 1'b0;
        if (!enable_i)
        begin
            state_d = aer_pkg::IDLE;                    // Pending hits stay latched
        end
        else
        begin
            case (state_q)
                aer_pkg::IDLE:
                begin
                    if (req_o)
                    begin
                        row_en  = 1'b1;                 // Pick a row
                        state_d = aer_pkg::ROW_GRANT;
                    end
                end
                aer_pkg::ROW_GRANT:
                begin
                    if (row_gnt != '0)
                    begin
                        col_en  = 1'b1;                 // First column of the row
                        state_d = aer_pkg::COL_GRANT;
                    end
                    else if (req_o)
                    begin
                        row_en = 1'b1;                  // Retry, new hits arrived
                    end
                    else
                    begin
                        state_d = aer_pkg::IDLE;        // Block drained
                    end
                end
                aer_pkg::COL_GRANT:
                begin
                    if (col_gnt == '0)
                    begin
                        row_en  = 1'b1;                 // Row exhausted, next row
                        state_d = aer_pkg::ROW_GRANT;
                    end
                    else
                    begin
                        col_en = 1'b1;                  // Keep sweeping columns
                    end
                end
                default:
                begin
                    state_d = aer_pkg::IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------------------------
    // Pixel grant at row and column intersection
    // --------------------------------------------------------------------

    always_comb
    begin
        for (int i = 0; i < `AER_ROWS; i++)
        begin
            for (int j = 0; j < `AER_COLS; j++)
            begin
                grant_o.map[i][j] = row_gnt[i] & col_gnt[j];
            end
        end
        grant_o.row   = row_addr;
        grant_o.col   = col_addr;
        grant_valid_o = enable_i && (state_q == aer_pkg::COL_GRANT)
                        && (row_gnt != '0) && (col_gnt != '0);
    end

    row_rr_arbiter i_row_rr_arbiter
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable_i      (row_en),
        .req_i         (row_req),
        .gnt_o         (row_gnt),
        .row_addr_o    (row_addr),
        .grp_release_o (grp_release_o)
    );

    col_rr_arbiter i_col_rr_arbiter
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable_i   (col_en),
        .req_i      (col_req),
        .gnt_o      (col_gnt),
        .col_addr_o (col_addr)
    );

endmodule

`default_nettype wire

// File: row_rr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "aer_defines.svh"

module row_rr_arbiter
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   enable_i,       // Run one arbitration this cycle
    input  wire logic [`AER_ROWS-1:0]   req_i,          // Rows with pending pixels
    output logic      [`AER_ROWS-1:0]   gnt_o,          // Registered one-hot row grant
    output logic      [`AER_ADDR_W-1:0] row_addr_o,     // Index of granted row
    output logic                        grp_release_o   // Sweep over rows wrapped
);

    logic [`AER_ADDR_W-1:0] ptr_q;                      // Search starts here
    logic [`AER_ADDR_W-1:0] pick;                       // Row chosen this cycle
    logic                   any_req;
    logic                   have_prev_q;                // A row was granted since reset

    assign any_req = |req_i;
    assign pick    = aer_pkg::rr_pick(req_i, ptr_q);    // At or after pointer

    // --------------------------------------------------------------------
    // Grant register, held while arbitration is idle
    // --------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            gnt_o         <= '0;
            row_addr_o    <= '0;
            ptr_q         <= '0;                        // Start at row 0
            have_prev_q   <= 1'b0;
            grp_release_o <= 1'b0;
        end
        else
        begin
            grp_release_o <= 1'b0;                      // Single-cycle pulse
            if (enable_i)
            begin
                gnt_o <= '0;                            // No active row gives no grant
                if (any_req)
                begin
                    gnt_o       <= `AER_ROWS'(1) << pick;
                    row_addr_o  <= pick;
                    ptr_q       <= pick + 1'b1;         // Next search one past this row
                    have_prev_q <= 1'b1;
                    // Same or lower index than last time means the sweep wrapped
                    grp_release_o <= have_prev_q && (pick <= row_addr_o);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_aer_readout.sv
`timescale 1ns/1ns
`default_nettype none

`include "aer_defines.svh"

module tb_aer_readout;

    localparam int RAND_CYCLES = 300;                   // Random hit stimulus length
    localparam int DRAIN_MAX   = 200;                   // Bound on one drain wait
    localparam int RUN_CYCLES  = 2 * 8 + RAND_CYCLES + 40 + 7 * DRAIN_MAX;

    logic                clk;
    logic                rst_n;
    logic                enable_i;
    aer_pkg::pix_map_t   hit_i;
    logic                hit_valid_i;
    aer_pkg::aer_event_t event_o;
    logic                event_valid_o;
    logic                req_o;
    logic                grp_release_o;

    aer_pkg::pix_map_t   model_map = '0;               // Hits not yet reported
    aer_pkg::pix_map_t   hit_dly   = '0;               // Hits sampled one edge ago
    int                  ev_count  = 0;
    int                  rel_count = 0;
    int                  fails     = 0;
    int                  last_row  = 0;
    int                  last_col  = 0;
    bit                  have_last = 1'b0;
    bit                  order_chk = 1'b0;             // Column order check active

    aer_readout_top i_aer_readout_top
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable_i      (enable_i),
        .hit_i         (hit_i),
        .hit_valid_i   (hit_valid_i),
        .event_o       (event_o),
        .event_valid_o (event_valid_o),
        .req_o         (req_o),
        .grp_release_o (grp_release_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                          // 8 ns period
    end

    // --------------------------------------------------------------------
    // Helpers
    // --------------------------------------------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // First requested column strictly after last, wrapping around the row
    function automatic int next_col(input logic [`AER_COLS-1:0] row_bits, input int last);
        int idx;
        int pick;
        pick = -1;
        for (int k = 1; k <= `AER_COLS; k++)
        begin
            idx = (last + k) % `AER_COLS;
            if (pick < 0 && row_bits[idx])
            begin
                pick = idx;
            end
        end
        return pick;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        fails++;
    endtask

    task automatic report_stall(input string what);
        $display("error at %0t ns: %s did not drain within %0d cycles", $time, what, DRAIN_MAX);
        fails++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;                                             // Drive just after the edge
    endtask

    task automatic apply_reset();
        rst_n       = 1'b1;                             // Reset is active high
        enable_i    = 1'b0;
        hit_i       = '0;
        hit_valid_i = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b0;
        assert (!event_valid_o && !req_o && !grp_release_o)
        else report_mismatch("outputs not low after reset");
    endtask

    task automatic strobe_hits(input aer_pkg::pix_map_t map);
        hit_i       = map;
        hit_valid_i = 1'b1;
        next_cycle();
        hit_i       = '0;
        hit_valid_i = 1'b0;
    endtask

    // Done once req_o has stayed low for a few cycles
    task automatic wait_drain(input string what);
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < 4 && waited < DRAIN_MAX)
        begin
            next_cycle();
            waited++;
            quiet = req_o ? 0 : quiet + 1;
        end
        assert (quiet >= 4) else report_stall(what);
    endtask

    task automatic end_test(input int num, input string name, input int f_before);
        $display("test %0d %-16s %s", num, name, (fails == f_before) ? "ok" : "FAILED");
    endtask

    // --------------------------------------------------------------------
    // Reference model and event monitor
    // --------------------------------------------------------------------

    always @(posedge clk)
    begin : monitor
        aer_pkg::pix_map_t m;
        int                r;
        int                c;
        if (rst_n)
        begin
            model_map = '0;
            hit_dly   = '0;
        end
        else
        begin
            m = model_map;
            if (event_valid_o)
            begin
                r = event_o.row;
                c = event_o.col;
                ev_count++;
                assert (m[r][c]) else report_mismatch("event on a pixel that is not pending");
                if (order_chk && have_last)
                begin
                    assert (c == next_col(m[r], last_col))
                    else report_mismatch("column out of round-robin order");
                    if (r != last_row)
                    begin
                        assert (m[last_row] == '0)
                        else report_mismatch("row changed with hits left in it");
                    end
                end
                m[r][c]   = 1'b0;                       // Event retires the hit
                last_row  = r;
                last_col  = c;
                have_last = 1'b1;
            end
            model_map = m | hit_dly;                    // Set after clear, as the latch does
            hit_dly   = hit_valid_i ? hit_i : '0;
            if (grp_release_o)
            begin
                rel_count++;
            end
        end
    end

    // --------------------------------------------------------------------
    // Tests
    // --------------------------------------------------------------------

    initial
    begin : tests
        logic [31:0]       rng;
        aer_pkg::pix_map_t map;
        aer_pkg::pix_map_t acc;
        int                ev0;
        int                rel0;
        int                f0;
        int                r;
        int                c;
        int                afail;
        rng = 32'hd9d1;
        apply_reset();

        f0  = fails;                                    // Single hit
        ev0 = ev_count;
        enable_i = 1'b1;
        rng = xorshift(rng);
        r   = rng[1:0];
        c   = rng[3:2];
        map = '0;
        map[r][c] = 1'b1;
        strobe_hits(map);
        assert (req_o) else report_mismatch("req_o low with a hit pending");
        wait_drain("single hit");
        assert (ev_count - ev0 == 1) else report_mismatch("single hit did not give one event");
        assert (last_row == r && last_col == c) else report_mismatch("single hit address");
        end_test(1, "single hit", f0);

        f0 = fails;                                     // Random bursts
        for (int i = 0; i < RAND_CYCLES; i++)
        begin
            rng = xorshift(rng);
            hit_i       = rng[31:16] & rng[15:0];       // Sparse hit maps
            hit_valid_i = rng[5] & rng[9];
            next_cycle();
        end
        hit_i       = '0;
        hit_valid_i = 1'b0;
        wait_drain("random bursts");
        assert (model_map == '0) else report_mismatch("hits left after random bursts");
        end_test(2, "random bursts", f0);

        f0  = fails;                                    // Merging
        ev0 = ev_count;
        enable_i = 1'b0;
        rng = xorshift(rng);
        r   = rng[1:0];
        c   = rng[3:2];
        map = '0;
        map[r][c] = 1'b1;
        repeat (3) strobe_hits(map);
        next_cycle();
        enable_i = 1'b1;
        wait_drain("merging");
        assert (ev_count - ev0 == 1) else report_mismatch("merged hits gave more than one event");
        assert (last_row == r && last_col == c) else report_mismatch("merged hit address");
        end_test(3, "merging", f0);

        f0  = fails;                                    // Row service order
        ev0 = ev_count;
        enable_i = 1'b0;
        rng = xorshift(rng);
        map = rng[15:0] | 16'h8421;                     // Every row has a hit
        strobe_hits(map);
        have_last = 1'b0;
        order_chk = 1'b1;
        enable_i  = 1'b1;
        wait_drain("row order");
        order_chk = 1'b0;
        assert (ev_count - ev0 == $countones(map)) else report_mismatch("row order event count");
        end_test(4, "row order", f0);

        f0  = fails;                                    // Enable gating
        ev0 = ev_count;
        enable_i = 1'b0;
        acc = '0;
        for (int i = 0; i < 10; i++)
        begin
            rng = xorshift(rng);
            map = rng[31:16] & rng[15:0];
            acc = acc | map;
            strobe_hits(map);
        end
        repeat (20) next_cycle();
        assert (ev_count == ev0) else report_mismatch("event while enable_i low");
        assert (req_o == (acc != '0)) else report_mismatch("pending hits not held");
        enable_i = 1'b1;
        wait_drain("enable gating");
        assert (ev_count - ev0 == $countones(acc)) else report_mismatch("gated hits not drained");
        assert (model_map == '0) else report_mismatch("hits left after enable gating");
        end_test(5, "enable gating", f0);

        f0 = fails;                                     // Group release
        apply_reset();
        enable_i = 1'b1;
        rel0 = rel_count;
        map  = '0;
        map[0] = 4'hf;                                  // One row only
        strobe_hits(map);
        wait_drain("single row");
        assert (rel_count == rel0) else report_mismatch("release while one row served");
        rel0 = rel_count;
        rng  = xorshift(rng);
        map  = '0;
        map[0] = rng[3:0] | 4'h1;
        map[1] = rng[7:4] | 4'h2;
        map[3] = rng[11:8] | 4'h8;
        strobe_hits(map);
        wait_drain("three rows");
        assert (rel_count - rel0 == 1) else report_mismatch("release count over one sweep");
        end_test(6, "group release", f0);

        afail = i_aer_readout_top.i_aer_event_encoder.i_aer_readout_asserts.fail_cnt;
        $display("summary: %0d events, %0d check errors, %0d assertion errors",
                 ev_count, fails, afail);
        if (fails + afail == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial
    begin
        #(RUN_CYCLES * 8 + 500);                        // All tests at their longest
        $display("timeout: tests did not finish in %0d cycles", RUN_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
